// File: hw/admission_pipeline.sv
////////////////////////////////////////
// Descriptor pipeline, queue occupancy
// and the admit or drop decision
////////////////////////////////////////

`timescale 1ns/10ps

module admission_pipeline import cong_man_pkg::*; (
    input  logic       counter_access,
    input  logic       rst_n,
    input  logic       packet_in_valid,
    input  egr_port_t  packet_in_port,
    input  prio_t      packet_in_prio,
    input  byte_len_t  packet_in_len,
    input  logic       packet_in_mark,
    output logic       packet_in_ready,
    output logic       packet_out_valid,
    output queue_id_t  packet_out_queue,
    output byte_len_t  packet_out_len,
    input  logic       packet_out_ready,
    input  logic       release_valid,
    input  queue_id_t  release_queue,
    input  occupancy_t release_bytes,
    output logic       lookup_valid,
    output queue_id_t  lookup_queue,
    input  occupancy_t lookup_threshold,
    output logic       drop_valid,
    output queue_id_t  drop_queue,
    output drop_type_t drop_type_sel
);

    logic        advance;
    logic        s1_valid;
    queue_id_t   s1_queue;
    byte_len_t   s1_len;
    logic        s1_police;
    logic        s2_valid;
    queue_id_t   s2_queue;
    byte_len_t   s2_len;
    logic        s2_police;
    logic [16:0] occ_plus_len;
    logic        queue_full;
    logic        admit;
    occupancy_t  occupancy [NUM_QUEUES];
    occupancy_t  occ_next  [NUM_QUEUES];

    // All stages move together, held while the output waits
    assign advance         = !packet_out_valid || packet_out_ready;
    assign packet_in_ready = advance;

    assign lookup_valid = s1_valid && advance;
    assign lookup_queue = s1_queue;

    ////////////////////////////////////////
    // Stage 2 decision

    assign occ_plus_len = {1'b0, occupancy[s2_queue]} + 17'(s2_len);
    assign queue_full   = occ_plus_len > {1'b0, lookup_threshold};
    assign admit        = s2_valid && advance && !s2_police && !queue_full;

    // Policer rule is checked first
    assign drop_valid    = s2_valid && advance && (s2_police || queue_full);
    assign drop_queue    = s2_queue;
    assign drop_type_sel = s2_police ? POLICER_DROP : QUEUE_FULL_DROP;

    always_comb begin
        occupancy_t grown;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            grown = occupancy[q];
            if (admit && s2_queue == queue_id_t'(q)) begin
                grown = grown + occupancy_t'(s2_len);
            end
            // Release saturates at zero
            if (release_valid && release_queue == queue_id_t'(q)) begin
                grown = (grown > release_bytes) ? grown - release_bytes : '0;
            end
            occ_next[q] = grown;
        end
    end

    ////////////////////////////////////////
    // Control state

    always_ff @(posedge counter_access or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid         <= 1'b0;
            s2_valid         <= 1'b0;
            packet_out_valid <= 1'b0;
            occupancy        <= '{default: '0};
        end else begin
            if (advance) begin
                s1_valid         <= packet_in_valid;
                s2_valid         <= s1_valid;
                packet_out_valid <= s2_valid && !s2_police && !queue_full;
            end
            occupancy <= occ_next;
        end
    end

    // Descriptor fields
    always_ff @(posedge counter_access) begin
        if (advance) begin
            s1_queue         <= {packet_in_port, prio_to_queue(packet_in_prio)};
            s1_len           <= packet_in_len;
            s1_police        <= packet_in_mark && packet_in_prio < prio_t'(6);
            s2_queue         <= s1_queue;
            s2_len           <= s1_len;
            s2_police        <= s1_police;
            packet_out_queue <= s2_queue;
            packet_out_len   <= s2_len;
        end
    end

    a_occ_within_thr: assert property (@(posedge counter_access) disable iff (!rst_n)
        admit |=> occupancy[$past(s2_queue)] <= $past(lookup_threshold));

endmodule

// File: hw/cong_man_pkg.sv
////////////////////////////////////////
// Shared sizes, vector types, enums and
// the priority to queue mapping
////////////////////////////////////////

package cong_man_pkg;

    ////////////////////////////////////////
    // Sizes

    localparam int NUM_EGR_PORTS   = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = NUM_EGR_PORTS * QUEUES_PER_PORT;
    localparam int NUM_DROP_TYPES  = 2;
    localparam int COUNTER_DEPTH   = NUM_QUEUES * NUM_DROP_TYPES;
    // One write per counter entry
    localparam int INIT_CYCLES     = COUNTER_DEPTH;
    localparam int MTU_BYTES       = 2000;

    ////////////////////////////////////////
    // Vector types

    typedef logic [$clog2(NUM_QUEUES)-1:0]    queue_id_t;
    typedef logic [$clog2(NUM_EGR_PORTS)-1:0] egr_port_t;
    typedef logic [2:0]                       prio_t;
    typedef logic [$clog2(MTU_BYTES)-1:0]     byte_len_t;
    typedef logic [15:0]                      occupancy_t;
    typedef logic [31:0]                      counter_t;
    // Queue in the upper bits, drop type in the LSB
    typedef logic [$clog2(COUNTER_DEPTH)-1:0] counter_addr_t;

    ////////////////////////////////////////
    // Enums

    typedef enum logic {
        POLICER_DROP    = 1'b0,
        QUEUE_FULL_DROP = 1'b1
    } drop_type_t;

    // Code 3 is unused and answered with an error
    typedef enum logic [1:0] {
        READ           = 2'd0,
        READ_AND_CLEAR = 2'd1,
        CLEAR_ALL      = 2'd2
    } counter_op_t;

    typedef enum logic {
        INIT,
        ACTIVE
    } host_state_t;

    ////////////////////////////////////////
    // Queue within the egress port

    function automatic logic [$clog2(QUEUES_PER_PORT)-1:0] prio_to_queue(input prio_t prio);
        case (prio)
            3'd7:    return 2'd3;
            3'd6:    return 2'd2;
            3'd5:    return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

endpackage

// File: hw/congestion_manager.sv
////////////////////////////////////////
// Egress admission top level
////////////////////////////////////////

`timescale 1ns/10ps

module congestion_manager import cong_man_pkg::*; (
    input  logic        counter_access,
    input  logic        rst_n,
    input  logic        packet_in_valid,
    input  egr_port_t   packet_in_port,
    input  prio_t       packet_in_prio,
    input  byte_len_t   packet_in_len,
    input  logic        packet_in_mark,
    output logic        packet_in_ready,
    output logic        packet_out_valid,
    output queue_id_t   packet_out_queue,
    output byte_len_t   packet_out_len,
    input  logic        packet_out_ready,
    input  logic        release_valid,
    input  queue_id_t   release_queue,
    input  occupancy_t  release_bytes,
    input  logic        cfg_req_valid,
    input  logic        cfg_write,
    input  queue_id_t   cfg_queue,
    input  occupancy_t  cfg_threshold,
    output logic        cfg_req_ready,
    output logic        cfg_rsp_valid,
    output occupancy_t  cfg_rsp_threshold,
    input  logic        cfg_rsp_ready,
    input  logic        cntr_req_valid,
    input  counter_op_t cntr_op,
    input  queue_id_t   cntr_queue,
    input  drop_type_t  cntr_type,
    output logic        cntr_req_ready,
    output logic        cntr_rsp_valid,
    output counter_t    cntr_rsp_data,
    output logic        cntr_rsp_error,
    input  logic        cntr_rsp_ready
);

    ////////////////////////////////////////
    // Internal nets

    logic          lookup_valid;
    queue_id_t     lookup_queue;
    occupancy_t    lookup_threshold;
    logic          drop_valid;
    queue_id_t     drop_queue;
    drop_type_t    drop_type_sel;
    logic          upd_rd_en;
    counter_addr_t upd_rd_addr;
    logic          upd_wr_en;
    counter_addr_t upd_wr_addr;
    counter_t      upd_wr_data;
    logic          host_req;
    counter_addr_t host_rd_addr;
    logic          host_wr_en;
    counter_addr_t host_wr_addr;
    counter_t      host_wr_data;
    logic          host_gnt;
    counter_t      bank_rd_data;

    ////////////////////////////////////////
    // Instances

    // Port names match the nets above
    admission_pipeline   i_admission_pipeline   (.*);
    drop_threshold_table i_drop_threshold_table (.*);
    counter_update_agent i_counter_update_agent (.*);
    counter_host_agent   i_counter_host_agent   (.*);
    counter_bank_arbiter i_counter_bank_arbiter (.*);

endmodule

// File: hw/counter_bank_arbiter.sv
////////////////////////////////////////
// Drop counter memory and access grant
////////////////////////////////////////

`timescale 1ns/10ps

module counter_bank_arbiter import cong_man_pkg::*; (
    input  logic          counter_access,
    input  logic          rst_n,
    input  logic          upd_rd_en,
    input  counter_addr_t upd_rd_addr,
    input  logic          upd_wr_en,
    input  counter_addr_t upd_wr_addr,
    input  counter_t      upd_wr_data,
    input  logic          host_req,
    input  counter_addr_t host_rd_addr,
    input  logic          host_wr_en,
    input  counter_addr_t host_wr_addr,
    input  counter_t      host_wr_data,
    output logic          host_gnt,
    output counter_t      bank_rd_data
);

    counter_t      counters [COUNTER_DEPTH];
    logic          wr_en;
    counter_addr_t wr_addr;
    counter_t      wr_data;
    counter_addr_t rd_addr;

    // Update agent never waits
    assign host_gnt = host_req && !upd_rd_en && !upd_wr_en;

    assign wr_en   = upd_wr_en || (host_gnt && host_wr_en);
    assign wr_addr = upd_wr_en ? upd_wr_addr : host_wr_addr;
    assign wr_data = upd_wr_en ? upd_wr_data : host_wr_data;
    assign rd_addr = upd_rd_en ? upd_rd_addr : host_rd_addr;

    // Read returns the value before a same-cycle write
    always_ff @(posedge counter_access) begin
        if (wr_en) begin
            counters[wr_addr] <= wr_data;
        end
        bank_rd_data <= counters[rd_addr];
    end

    a_single_writer: assert property (@(posedge counter_access) disable iff (!rst_n)
        !(upd_wr_en && host_wr_en));

endmodule

// File: hw/counter_host_agent.sv
////////////////////////////////////////
// Counter clearing sweep and host requests
////////////////////////////////////////

`timescale 1ns/10ps

module counter_host_agent import cong_man_pkg::*; (
    input  logic          counter_access,
    input  logic          rst_n,
    input  logic          cntr_req_valid,
    input  counter_op_t   cntr_op,
    input  queue_id_t     cntr_queue,
    input  drop_type_t    cntr_type,
    output logic          cntr_req_ready,
    output logic          cntr_rsp_valid,
    output counter_t      cntr_rsp_data,
    output logic          cntr_rsp_error,
    input  logic          cntr_rsp_ready,
    output logic          host_req,
    output counter_addr_t host_rd_addr,
    output logic          host_wr_en,
    output counter_addr_t host_wr_addr,
    output counter_t      host_wr_data,
    input  logic          host_gnt,
    input  counter_t      bank_rd_data
);

    host_state_t   state;
    counter_addr_t sweep_addr;
    logic          pend;
    counter_addr_t pend_addr;
    logic          pend_clear;
    logic          rd_wait;
    logic          req_accept;

    assign cntr_req_ready = state == ACTIVE && !pend && !rd_wait && !cntr_rsp_valid;
    assign req_accept     = cntr_req_valid && cntr_req_ready;

    ////////////////////////////////////////
    // Memory side

    assign host_req     = state == INIT || pend;
    assign host_rd_addr = pend_addr;
    // Sweep writes, or the clear half of READ_AND_CLEAR
    assign host_wr_en   = host_gnt && (state == INIT || pend_clear);
    assign host_wr_addr = (state == INIT) ? sweep_addr : pend_addr;
    assign host_wr_data = '0;

    always_ff @(posedge counter_access or negedge rst_n) begin
        if (!rst_n) begin
            state          <= INIT;
            sweep_addr     <= '0;
            pend           <= 1'b0;
            rd_wait        <= 1'b0;
            cntr_rsp_valid <= 1'b0;
        end else begin
            rd_wait <= 1'b0;
            if (cntr_rsp_valid && cntr_rsp_ready) begin
                cntr_rsp_valid <= 1'b0;
            end
            case (state)
                INIT: begin
                    if (host_gnt) begin
                        sweep_addr <= sweep_addr + 1'b1;
                        if (sweep_addr == counter_addr_t'(INIT_CYCLES - 1)) begin
                            state <= ACTIVE;
                        end
                    end
                end
                ACTIVE: begin
                    if (req_accept) begin
                        case (cntr_op)
                            READ, READ_AND_CLEAR: pend <= 1'b1;
                            CLEAR_ALL: begin
                                state          <= INIT;
                                cntr_rsp_valid <= 1'b1;
                            end
                            default: cntr_rsp_valid <= 1'b1;
                        endcase
                    end
                    if (pend && host_gnt) begin
                        pend    <= 1'b0;
                        rd_wait <= 1'b1;
                    end
                    // Read data is back from the bank
                    if (rd_wait) begin
                        cntr_rsp_valid <= 1'b1;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    always_ff @(posedge counter_access) begin
        if (req_accept) begin
            pend_addr      <= {cntr_queue, cntr_type};
            pend_clear     <= cntr_op == READ_AND_CLEAR;
            cntr_rsp_data  <= '0;
            cntr_rsp_error <= !(cntr_op inside {READ, READ_AND_CLEAR, CLEAR_ALL});
        end
        if (rd_wait) begin
            cntr_rsp_data  <= bank_rd_data;
            cntr_rsp_error <= 1'b0;
        end
    end

    // A stray grant would let a stale clear reach the memory
    a_gnt_requested: assert property (@(posedge counter_access) disable iff (!rst_n)
        host_gnt |-> host_req);

endmodule

// File: hw/counter_update_agent.sv
////////////////////////////////////////
// Drop counter increment agent
////////////////////////////////////////

`timescale 1ns/10ps

module counter_update_agent import cong_man_pkg::*; (
    input  logic          counter_access,
    input  logic          rst_n,
    input  logic          drop_valid,
    input  queue_id_t     drop_queue,
    input  drop_type_t    drop_type_sel,
    output logic          upd_rd_en,
    output counter_addr_t upd_rd_addr,
    output logic          upd_wr_en,
    output counter_addr_t upd_wr_addr,
    output counter_t      upd_wr_data,
    input  counter_t      bank_rd_data
);

    logic          pend_valid;
    counter_addr_t pend_addr;
    logic          last_valid;
    counter_addr_t last_addr;
    counter_t      last_data;
    logic          forward;

    // Read in the event cycle
    assign upd_rd_en   = drop_valid;
    assign upd_rd_addr = {drop_queue, drop_type_sel};

    // Memory read missed the write still in flight to the same counter
    assign forward = last_valid && last_addr == pend_addr;

    assign upd_wr_en   = pend_valid;
    assign upd_wr_addr = pend_addr;
    assign upd_wr_data = (forward ? last_data : bank_rd_data) + counter_t'(1);

    always_ff @(posedge counter_access or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            pend_valid <= drop_valid;
            last_valid <= pend_valid;
        end
    end

    always_ff @(posedge counter_access) begin
        pend_addr <= upd_rd_addr;
        last_addr <= pend_addr;
        last_data <= upd_wr_data;
    end

endmodule

// File: hw/drop_threshold_table.sv
////////////////////////////////////////
// Per-queue drop thresholds with packet
// lookup and configuration access
////////////////////////////////////////

`timescale 1ns/10ps

module drop_threshold_table import cong_man_pkg::*; (
    input  logic       counter_access,
    input  logic       rst_n,
    input  logic       lookup_valid,
    input  queue_id_t  lookup_queue,
    output occupancy_t lookup_threshold,
    input  logic       cfg_req_valid,
    input  logic       cfg_write,
    input  queue_id_t  cfg_queue,
    input  occupancy_t cfg_threshold,
    output logic       cfg_req_ready,
    output logic       cfg_rsp_valid,
    output occupancy_t cfg_rsp_threshold,
    input  logic       cfg_rsp_ready
);

    occupancy_t thresholds [NUM_QUEUES];
    logic       cfg_accept;

    // Packet lookups take the table, config waits
    assign cfg_req_ready = !lookup_valid && !cfg_rsp_valid;
    assign cfg_accept    = cfg_req_valid && cfg_req_ready;

    always_ff @(posedge counter_access or negedge rst_n) begin
        if (!rst_n) begin
            thresholds    <= '{default: '1};
            cfg_rsp_valid <= 1'b0;
        end else begin
            if (cfg_accept) begin
                if (cfg_write) begin
                    thresholds[cfg_queue] <= cfg_threshold;
                end
                cfg_rsp_valid <= 1'b1;
            end else if (cfg_rsp_ready) begin
                cfg_rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge counter_access) begin
        if (lookup_valid) begin
            lookup_threshold <= thresholds[lookup_queue];
        end
        // Write echoes the new value
        if (cfg_accept) begin
            cfg_rsp_threshold <= cfg_write ? cfg_threshold : thresholds[cfg_queue];
        end
    end

    a_cfg_rsp_hold: assert property (@(posedge counter_access) disable iff (!rst_n)
        cfg_rsp_valid && !cfg_rsp_ready |=> cfg_rsp_valid && $stable(cfg_rsp_threshold));

endmodule

// File: run.sh
#!/bin/sh
# Build and run the congestion manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/10ps \
    -f vlog.f \
    --top-module tb_congestion_manager \
    -Mdir obj_dir -o sim_congestion_manager
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/sim_congestion_manager
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit $sim_status
fi

exit 0

// File: tb/tb_clock_gen.sv
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
    output logic counter_access,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        counter_access = 1'b0;
        forever #(HALF_PERIOD) counter_access = ~counter_access;
    end

    // Release lines up with the input drive point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge counter_access);
        #10;
        rst_n = 1'b1;
    end

endmodule

// File: tb/tb_congestion_manager.sv
////////////////////////////////////////
// Congestion manager testbench with random
// stimulus, reference model and watchdog
////////////////////////////////////////

`timescale 1ns/10ps

module tb_congestion_manager import cong_man_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int N_MAP          = 150;
    localparam int N_POLICE       = 150;
    localparam int N_FULL         = 150;
    localparam int N_RELEASE      = 100;
    localparam int N_BACKPRESSURE = 200;
    localparam int STREAM_PKTS    = N_MAP + N_POLICE + N_FULL + N_RELEASE + N_BACKPRESSURE;
    localparam int CNTR_OPS       = 8 * NUM_QUEUES + 4;
    localparam int CFG_OPS        = 2 * NUM_QUEUES;
    localparam int WAIT_LIMIT     = INIT_CYCLES + 16;
    localparam int STALL_LIMIT    = 64;
    // Streams take a few cycles per packet and each request up to two waits
    localparam int WATCHDOG_CYCLES = 4 * STREAM_PKTS + 2 * WAIT_LIMIT * (CNTR_OPS + CFG_OPS)
                                     + 2000;

    logic        counter_access;
    logic        rst_n;
    logic        packet_in_valid;
    egr_port_t   packet_in_port;
    prio_t       packet_in_prio;
    byte_len_t   packet_in_len;
    logic        packet_in_mark;
    logic        packet_in_ready;
    logic        packet_out_valid;
    queue_id_t   packet_out_queue;
    byte_len_t   packet_out_len;
    logic        packet_out_ready;
    logic        release_valid;
    queue_id_t   release_queue;
    occupancy_t  release_bytes;
    logic        cfg_req_valid;
    logic        cfg_write;
    queue_id_t   cfg_queue;
    occupancy_t  cfg_threshold;
    logic        cfg_req_ready;
    logic        cfg_rsp_valid;
    occupancy_t  cfg_rsp_threshold;
    logic        cfg_rsp_ready;
    logic        cntr_req_valid;
    counter_op_t cntr_op;
    queue_id_t   cntr_queue;
    drop_type_t  cntr_type;
    logic        cntr_req_ready;
    logic        cntr_rsp_valid;
    counter_t    cntr_rsp_data;
    logic        cntr_rsp_error;
    logic        cntr_rsp_ready;

    logic [31:0] lfsr_state = 32'h6d147476;

    // Reference model
    int          model_thr [NUM_QUEUES];
    int          model_occ [NUM_QUEUES];
    logic [31:0] model_cnt [COUNTER_DEPTH];
    // Admitted packets as {queue, length}
    logic [14:0] expected_out [$];

    tb_clock_gen i_clock_gen (.*);

    congestion_manager i_congestion_manager (.*);

    ////////////////////////////////////////
    // Helpers

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int expected_queue(input int port, input int prio);
        int local_q;
        case (prio)
            7:       local_q = 3;
            6:       local_q = 2;
            5:       local_q = 1;
            default: local_q = 0;
        endcase
        return port * QUEUES_PER_PORT + local_q;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopping simulation");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            abort_run($sformatf("** Error: [%s] expected %0d, actual %0d",
                                name, expected, actual));
        end
    endtask

    task automatic to_drive_point();
        @(posedge counter_access);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_one_cycle(inout int waited, input string what);
        waited++;
        assert (waited < WAIT_LIMIT) else begin
            abort_run($sformatf("Timed out waiting for %s", what));
        end
        @(negedge counter_access);
    endtask

    ////////////////////////////////////////
    // Packet stream

    task automatic load_packet(input int mark_mode, input int max_len);
        packet_in_port = egr_port_t'(random_bits(2));
        packet_in_prio = prio_t'(random_bits(3));
        packet_in_len  = byte_len_t'(1 + random_bits(11) % max_len);
        packet_in_mark = (mark_mode == 2) ? 1'(random_bits(1)) : 1'(mark_mode);
    endtask

    // Decide the accepted packet by the admission rules
    task automatic model_packet();
        int q;
        q = expected_queue(int'(packet_in_port), int'(packet_in_prio));
        if (packet_in_mark && packet_in_prio < 6) begin
            model_cnt[2 * q] += 1;
        end else if (model_occ[q] + int'(packet_in_len) > model_thr[q]) begin
            model_cnt[2 * q + 1] += 1;
        end else begin
            model_occ[q] += int'(packet_in_len);
            expected_out.push_back({4'(q), packet_in_len});
        end
    endtask

    task automatic check_output(input string name);
        logic [14:0] item;
        assert (expected_out.size() > 0) else begin
            abort_run($sformatf("%s: packet_out sent a packet that should have been dropped",
                                name));
        end
        item = expected_out.pop_front();
        check_value({name, " queue"}, 32'(item[14:11]), 32'(packet_out_queue));
        check_value({name, " length"}, 32'(item[10:0]), 32'(packet_out_len));
    endtask

    task automatic run_stream(input string name, input int count, input int mark_mode,
                              input int max_len, input bit backpressure);
        int sent;
        int stalled;
        bit in_fire;
        bit out_fire;
        sent = 0;
        stalled = 0;
        load_packet(mark_mode, max_len);
        packet_in_valid = 1'b1;
        while (sent < count || expected_out.size() > 0) begin
            packet_out_ready = backpressure ? 1'(random_bits(1)) : 1'b1;
            @(negedge counter_access);
            in_fire  = packet_in_valid && packet_in_ready;
            out_fire = packet_out_valid && packet_out_ready;
            if (out_fire) begin
                check_output(name);
            end
            if (in_fire) begin
                model_packet();
                sent++;
            end
            stalled = (in_fire || out_fire) ? 0 : stalled + 1;
            assert (stalled < STALL_LIMIT) else begin
                abort_run($sformatf("%s: packet stream made no progress", name));
            end
            to_drive_point();
            if (in_fire && sent < count) begin
                load_packet(mark_mode, max_len);
            end else if (in_fire) begin
                packet_out_ready = packet_out_ready;
                packet_in_valid = 1'b0;
            end
        end
        packet_out_ready = 1'b1;
        // Let the last drops reach the counter memory
        repeat (6) begin
            @(negedge counter_access);
            assert (!packet_out_valid) else begin
                abort_run($sformatf("%s: packet_out sent an unexpected packet", name));
            end
            to_drive_point();
        end
    endtask

    ////////////////////////////////////////
    // Configuration, release and counters

    task automatic cfg_access(input bit write, input int queue, input int threshold,
                              output logic [15:0] rsp);
        int waited;
        int hold;
        cfg_write     = write;
        cfg_queue     = queue_id_t'(queue);
        cfg_threshold = occupancy_t'(threshold);
        cfg_req_valid = 1'b1;
        cfg_rsp_ready = 1'b0;
        waited = 0;
        @(negedge counter_access);
        while (!cfg_req_ready) begin
            wait_one_cycle(waited, "cfg_req_ready");
        end
        to_drive_point();
        cfg_req_valid = 1'b0;
        waited = 0;
        @(negedge counter_access);
        while (!cfg_rsp_valid) begin
            wait_one_cycle(waited, "cfg_rsp_valid");
        end
        rsp = cfg_rsp_threshold;
        // Response held back for a few cycles
        hold = int'(random_bits(2));
        repeat (hold) begin
            to_drive_point();
            @(negedge counter_access);
            assert (cfg_rsp_valid && cfg_rsp_threshold == rsp) else begin
                abort_run("cfg response dropped or changed while cfg_rsp_ready was low");
            end
        end
        to_drive_point();
        cfg_rsp_ready = 1'b1;
        to_drive_point();
    endtask

    task automatic apply_release(input int queue, input int bytes);
        release_valid = 1'b1;
        release_queue = queue_id_t'(queue);
        release_bytes = occupancy_t'(bytes);
        model_occ[queue] = (model_occ[queue] > bytes) ? model_occ[queue] - bytes : 0;
        to_drive_point();
        release_valid = 1'b0;
    endtask

    task automatic counter_request(input counter_op_t op, input int queue, input int ctype,
                                   output logic [31:0] data, output logic error);
        int waited;
        cntr_op        = op;
        cntr_queue     = queue_id_t'(queue);
        cntr_type      = drop_type_t'(ctype);
        cntr_req_valid = 1'b1;
        waited = 0;
        @(negedge counter_access);
        while (!cntr_req_ready) begin
            wait_one_cycle(waited, "cntr_req_ready");
        end
        to_drive_point();
        cntr_req_valid = 1'b0;
        waited = 0;
        @(negedge counter_access);
        while (!cntr_rsp_valid) begin
            wait_one_cycle(waited, "cntr_rsp_valid");
        end
        data  = cntr_rsp_data;
        error = cntr_rsp_error;
        to_drive_point();
    endtask

    task automatic check_counter(input string name, input int queue, input int ctype);
        logic [31:0] data;
        logic        error;
        counter_request(READ, queue, ctype, data, error);
        check_value({name, " error flag"}, 0, 32'(error));
        check_value($sformatf("%s counter q%0d t%0d", name, queue, ctype),
                    model_cnt[2 * queue + ctype], data);
    endtask

    task automatic check_counters(input string name, input int ctype);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            check_counter(name, q, ctype);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] rsp_data;
        logic        rsp_error;
        logic [15:0] rsp_thr;
        int          thr;
        packet_in_valid  = 1'b0;
        packet_in_port   = '0;
        packet_in_prio   = '0;
        packet_in_len    = '0;
        packet_in_mark   = 1'b0;
        packet_out_ready = 1'b1;
        release_valid    = 1'b0;
        release_queue    = '0;
        release_bytes    = '0;
        cfg_req_valid    = 1'b0;
        cfg_write        = 1'b0;
        cfg_queue        = '0;
        cfg_threshold    = '0;
        cfg_rsp_ready    = 1'b1;
        cntr_req_valid   = 1'b0;
        cntr_op          = READ;
        cntr_queue       = '0;
        cntr_type        = POLICER_DROP;
        cntr_rsp_ready   = 1'b1;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            model_thr[q] = 65535;
            model_occ[q] = 0;
        end
        for (int a = 0; a < COUNTER_DEPTH; a++) begin
            model_cnt[a] = '0;
        end

        // Reset state and the clearing sweep
        @(posedge rst_n);
        @(negedge counter_access);
        check_value("reset packet_out_valid", 0, 32'(packet_out_valid));
        check_value("reset cfg_rsp_valid", 0, 32'(cfg_rsp_valid));
        check_value("reset cntr_rsp_valid", 0, 32'(cntr_rsp_valid));
        to_drive_point();
        check_counter("reset", 0, 0);
        check_counter("reset", NUM_QUEUES - 1, 1);

        run_stream("mapping", N_MAP, 0, MTU_BYTES, 1'b0);

        run_stream("policer", N_POLICE, 1, MTU_BYTES, 1'b0);
        check_counters("policer", 0);

        // Empty all queues before the small thresholds go in
        for (int q = 0; q < NUM_QUEUES; q++) begin
            apply_release(q, 65535);
        end
        for (int q = 0; q < NUM_QUEUES; q++) begin
            thr = 600 + int'(random_bits(12));
            cfg_access(1'b1, q, thr, rsp_thr);
            check_value("threshold write", thr, 32'(rsp_thr));
            model_thr[q] = thr;
        end
        for (int q = 0; q < NUM_QUEUES; q++) begin
            cfg_access(1'b0, q, 0, rsp_thr);
            check_value("threshold readback", model_thr[q], 32'(rsp_thr));
        end
        run_stream("queue full", N_FULL, 0, 600, 1'b0);
        check_counters("queue full", 1);

        for (int q = 0; q < NUM_QUEUES; q++) begin
            apply_release(q, int'(random_bits(11)));
        end
        run_stream("release", N_RELEASE, 2, 600, 1'b0);
        check_counters("release", 0);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            counter_request(READ_AND_CLEAR, q, 1, rsp_data, rsp_error);
            check_value("read and clear value", model_cnt[2 * q + 1], rsp_data);
            model_cnt[2 * q + 1] = '0;
        end
        check_counters("after read and clear", 1);
        counter_request(CLEAR_ALL, 0, 0, rsp_data, rsp_error);
        check_value("clear all error flag", 0, 32'(rsp_error));
        for (int a = 0; a < COUNTER_DEPTH; a++) begin
            model_cnt[a] = '0;
        end
        check_counters("after clear all", 0);
        counter_request(counter_op_t'(2'd3), 0, 0, rsp_data, rsp_error);
        check_value("unused op error flag", 1, 32'(rsp_error));

        for (int q = 0; q < NUM_QUEUES; q++) begin
            apply_release(q, 65535);
        end
        run_stream("backpressure", N_BACKPRESSURE, 2, 600, 1'b1);
        check_counters("backpressure", 0);
        check_counters("backpressure", 1);

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

endmodule

// File: vlog.f
hw/cong_man_pkg.sv
hw/drop_threshold_table.sv
hw/admission_pipeline.sv
hw/counter_update_agent.sv
hw/counter_host_agent.sv
hw/counter_bank_arbiter.sv
hw/congestion_manager.sv
tb/tb_clock_gen.sv
tb/tb_congestion_manager.sv
